// ==== logic/rv32v_types_pkg.sv ====
// Shared decode types, vector control encodings and bus addresses; imported by the decode stages
`default_nettype none

package rv32v_types_pkg;

    // element width code, 4..7 are reserved encodings
    typedef enum logic [2:0] {
        SEW8  = 3'd0,
        SEW16 = 3'd1,
        SEW32 = 3'd2,
        SEW64 = 3'd3
    } vsew_t;

    typedef enum logic [2:0] {
        OPIVV = 3'd0,
        OPFVV = 3'd1,
        OPMVV = 3'd2,
        OPIVI = 3'd3,
        OPIVX = 3'd4,
        OPFVF = 3'd5,
        OPMVX = 3'd6,
        OPCFG = 3'd7
    } vfunct3_t;

    // OPM funct6 encodings
    typedef enum logic [5:0] {
        VREDSUM     = 6'b000000,
        VREDAND     = 6'b000001,
        VREDOR      = 6'b000010,
        VREDXOR     = 6'b000011,
        VREDMINU    = 6'b000100,
        VREDMIN     = 6'b000101,
        VREDMAXU    = 6'b000110,
        VREDMAX     = 6'b000111,
        VAADDU      = 6'b001000,
        VAADD       = 6'b001001,
        VASUBU      = 6'b001010,
        VASUB       = 6'b001011,
        VSLIDE1UP   = 6'b001110,
        VSLIDE1DOWN = 6'b001111,
        VWXUNARY0   = 6'b010000,
        VXUNARY0    = 6'b010010,
        VMUNARY0    = 6'b010100,
        VCOMPRESS   = 6'b010111,
        VMANDN      = 6'b011000,
        VMAND       = 6'b011001,
        VMOR        = 6'b011010,
        VMXOR       = 6'b011011,
        VMORN       = 6'b011100,
        VMNAND      = 6'b011101,
        VMNOR       = 6'b011110,
        VMXNOR      = 6'b011111,
        VDIVU       = 6'b100000,
        VDIV        = 6'b100001,
        VREMU       = 6'b100010,
        VREM        = 6'b100011,
        VMULHU      = 6'b100100,
        VMUL        = 6'b100101,
        VMULHSU     = 6'b100110,
        VMULH       = 6'b100111,
        VMADD       = 6'b101001,
        VNMSUB      = 6'b101011,
        VMACC       = 6'b101101,
        VNMSAC      = 6'b101111,
        VWADDU      = 6'b110000,
        VWADD       = 6'b110001,
        VWSUBU      = 6'b110010,
        VWSUB       = 6'b110011,
        VWADDU_W    = 6'b110100,
        VWADD_W     = 6'b110101,
        VWSUBU_W    = 6'b110110,
        VWSUB_W     = 6'b110111,
        VWMULU      = 6'b111000,
        VWMULSU     = 6'b111010,
        VWMUL       = 6'b111011,
        VWMACCU     = 6'b111100,
        VWMACC      = 6'b111101,
        VWMACCUS    = 6'b111110,
        VWMACCSU    = 6'b111111
    } vopm_t;

    typedef enum logic [2:0] {VFU_ALU, VFU_RED, VFU_PRM, VFU_MSK, VFU_DIV, VFU_MUL} vfu_t;

    typedef enum logic [2:0] {
        VALU_ADD, VALU_SUB, VALU_AND, VALU_OR, VALU_XOR, VALU_MIN, VALU_MAX, VALU_EXT
    } valuop_t;

    typedef enum logic [2:0] {UNFUSED, VMUL_MADD, VMUL_NMSUB, VMUL_MACC, VMUL_NMSAC} vmulop_t;

    typedef enum logic [2:0] {
        VMSK_AND, VMSK_NDN, VMSK_OR, VMSK_XOR, VMSK_NOR, VMSK_NND, VMSK_XNR
    } vmaskop_t;

    typedef enum logic [1:0] {VPRM_CPS, VPRM_S1U, VPRM_S1D} vpermop_t;

    typedef enum logic [1:0] {SIGNED, UNSIGNED, SIGNED_UNSIGNED, UNSIGNED_SIGNED} vsigntype_t;

    typedef struct packed {
        vfu_t       vfu;
        valuop_t    valuop;
        vmulop_t    vmulop;
        logic       vmulwiden;
        logic       vmulrethigh;
        logic       vdivremainder;
        vmaskop_t   vmaskop;
        vpermop_t   vpermop;
        vsigntype_t vsigntype;
        logic       vopunsigned;
    } vexec_t;

    typedef struct packed {
        logic       opcode_ok;
        vopm_t      vopm;
        vfunct3_t   vfunct3;
        logic [4:0] vs1;    // also rs1 for .vx forms
        logic [4:0] vs2;
        logic [4:0] vd;
        logic       vm;
        vsew_t      vsew;
    } split_pkt_t;

    typedef struct packed {
        vexec_t     vexec;
        vsew_t      veew_src2;
        logic [4:0] vs1;
        logic [4:0] vs2;
        logic [4:0] vd;
        logic       vm;
        logic       illegal;
    } uop_t;

    localparam logic [6:0] op_v_opcode = 7'b1010111;

    localparam logic wb_addr_vsew  = 1'b0;   // word addresses on the slave port
    localparam logic wb_addr_instr = 1'b1;

endpackage

`default_nettype wire

// ==== logic/vdec_wb_front.sv ====
// Wishbone classic slave front end: holds vsew and captures instruction words into the first slot
`timescale 1ns/10ps
`default_nettype none

module vdec_wb_front
    import rv32v_types_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n,
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  logic        wb_adr,
    input  logic [31:0] wb_dat_w,
    input  logic [3:0]  wb_sel,
    output logic        wb_ack,
    output logic [31:0] wb_dat_r,
    output logic        out_valid,
    input  logic        out_ready,
    output logic [31:0] out_instr,
    output vsew_t       out_vsew
);

    vsew_t cur_vsew;
    logic  req;
    logic  bus_done;
    logic  slot_free;
    logic  instr_wr;

    assign req       = wb_cyc && wb_stb && !wb_ack;   // ack cycle is never a new request
    assign bus_done  = wb_cyc && wb_stb && wb_ack;
    assign slot_free = !out_valid || out_ready;        // empty or handing off this edge
    assign instr_wr  = bus_done && wb_we && (wb_adr == wb_addr_instr);

    // instruction address reads back as zero
    assign wb_dat_r = (wb_adr == wb_addr_vsew) ? {29'd0, cur_vsew} : 32'd0;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= req && (!wb_we || (wb_adr == wb_addr_vsew) || slot_free);
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cur_vsew <= SEW8;
        end else if (bus_done && wb_we && (wb_adr == wb_addr_vsew) && wb_sel[0]) begin
            cur_vsew <= vsew_t'(wb_dat_w[2:0]);   // byte lane 0 only
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
        end else if (instr_wr) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (instr_wr) begin
            out_instr <= wb_dat_w;
            out_vsew  <= cur_vsew;   // width in force when the word lands
        end
    end

    // one ack per request, even with requests back to back
    a_single_ack: assert property (@(posedge clk) disable iff (!arst_n) wb_ack |=> !wb_ack);

    // slot space granted at the ack decision is still there at capture
    a_no_overwrite: assert property (@(posedge clk) disable iff (!arst_n)
        instr_wr |-> !out_valid);

endmodule

`default_nettype wire

// ==== logic/vdec_pipe_reg.sv ====
// One-entry valid/ready register slice with full throughput, payload type set by the instance
`timescale 1ns/10ps
`default_nettype none

module vdec_pipe_reg #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    // takes a new item in the same cycle the held one leaves
    assign in_ready = !out_valid || out_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            out_data <= in_data;
        end
    end

    // a stalled item is held as is until taken
    a_hold_stable: assert property (@(posedge clk) disable iff (!arst_n)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_data)));

endmodule

`default_nettype wire

// ==== logic/rv32v_field_split.sv ====
// Combinational field split of an instruction word into the packet handed to the OPM decoder
`timescale 1ns/10ps
`default_nettype none

module rv32v_field_split
    import rv32v_types_pkg::*;
(
    input  logic [31:0] instr,
    input  vsew_t       vsew,
    output split_pkt_t  pkt
);

    // valid/ready of this stage is wired around it at the top level
    always_comb begin
        pkt.opcode_ok = (instr[6:0] == op_v_opcode);   // OP-V major opcode
        pkt.vopm      = vopm_t'(instr[31:26]);
        pkt.vm        = instr[25];
        pkt.vs2       = instr[24:20];
        pkt.vs1       = instr[19:15];   // rs1 for .vx
        pkt.vfunct3   = vfunct3_t'(instr[14:12]);
        pkt.vd        = instr[11:7];
        pkt.vsew      = vsew;
    end

endmodule

`default_nettype wire

// ==== logic/rv32v_opm_decode.sv ====
// Combinational OPM decoder from funct6 to execution unit controls, source-2 width and legality
`timescale 1ns/10ps
`default_nettype none

module rv32v_opm_decode
    import rv32v_types_pkg::*;
(
    input  split_pkt_t pkt,
    output uop_t       uop
);

    logic       known;       // funct6 names a supported op
    logic       funct3_ok;

    assign funct3_ok = pkt.vfunct3 inside {OPMVV, OPMVX};

    always_comb begin
        known                  = 1'b1;
        uop.vexec.vfu          = VFU_ALU;
        uop.vexec.valuop       = VALU_ADD;
        uop.vexec.vmulop       = UNFUSED;
        uop.vexec.vmaskop      = VMSK_AND;
        uop.vexec.vpermop      = VPRM_CPS;
        uop.vexec.vsigntype    = SIGNED;
        uop.veew_src2          = pkt.vsew;

        // unit select, unary groups fall to default
        case (pkt.vopm)
            VREDSUM, VREDAND, VREDOR, VREDXOR,
            VREDMINU, VREDMIN, VREDMAXU, VREDMAX:  uop.vexec.vfu = VFU_RED;
            VAADDU, VAADD, VASUBU, VASUB,
            VWADDU, VWADD, VWSUBU, VWSUB,
            VWADDU_W, VWADD_W, VWSUBU_W, VWSUB_W:  uop.vexec.vfu = VFU_ALU;
            VSLIDE1UP, VSLIDE1DOWN, VCOMPRESS:     uop.vexec.vfu = VFU_PRM;
            VMANDN, VMAND, VMOR, VMXOR,
            VMORN, VMNAND, VMNOR, VMXNOR:          uop.vexec.vfu = VFU_MSK;
            VDIVU, VDIV, VREMU, VREM:              uop.vexec.vfu = VFU_DIV;
            VMULHU, VMUL, VMULHSU, VMULH,
            VMADD, VNMSUB, VMACC, VNMSAC,
            VWMULU, VWMULSU, VWMUL,
            VWMACCU, VWMACC, VWMACCUS, VWMACCSU:   uop.vexec.vfu = VFU_MUL;
            default:                               known = 1'b0;
        endcase

        case (pkt.vopm)
            VREDAND:                       uop.vexec.valuop = VALU_AND;
            VREDOR:                        uop.vexec.valuop = VALU_OR;
            VREDXOR:                       uop.vexec.valuop = VALU_XOR;
            VREDMINU, VREDMIN:             uop.vexec.valuop = VALU_MIN;
            VREDMAXU, VREDMAX:             uop.vexec.valuop = VALU_MAX;
            VASUBU, VASUB, VWSUBU, VWSUB,
            VWSUBU_W, VWSUB_W:             uop.vexec.valuop = VALU_SUB;
            default:                       uop.vexec.valuop = VALU_ADD;
        endcase

        case (pkt.vopm)
            VMADD:                                    uop.vexec.vmulop = VMUL_MADD;
            VNMSUB:                                   uop.vexec.vmulop = VMUL_NMSUB;
            VMACC, VWMACCU, VWMACC, VWMACCUS, VWMACCSU: uop.vexec.vmulop = VMUL_MACC;
            VNMSAC:                                   uop.vexec.vmulop = VMUL_NMSAC;
            default:                                  uop.vexec.vmulop = UNFUSED;
        endcase

        case (pkt.vopm)
            VMANDN:        uop.vexec.vmaskop = VMSK_NDN;
            VMOR:          uop.vexec.vmaskop = VMSK_OR;
            VMXOR:         uop.vexec.vmaskop = VMSK_XOR;
            VMORN, VMNOR:  uop.vexec.vmaskop = VMSK_NOR;   // orn shares the nor code
            VMNAND:        uop.vexec.vmaskop = VMSK_NND;
            VMXNOR:        uop.vexec.vmaskop = VMSK_XNR;
            default:       uop.vexec.vmaskop = VMSK_AND;
        endcase

        case (pkt.vopm)
            VSLIDE1UP:    uop.vexec.vpermop = VPRM_S1U;
            VSLIDE1DOWN:  uop.vexec.vpermop = VPRM_S1D;
            default:      uop.vexec.vpermop = VPRM_CPS;
        endcase

        case (pkt.vopm)
            VMULHU, VWMULU, VWMACCU:     uop.vexec.vsigntype = UNSIGNED;
            VMULHSU, VWMULSU, VWMACCSU:  uop.vexec.vsigntype = SIGNED_UNSIGNED;
            VWMACCUS:                    uop.vexec.vsigntype = UNSIGNED_SIGNED;
            default:                     uop.vexec.vsigntype = SIGNED;
        endcase

        uop.vexec.vmulwiden = pkt.vopm inside {VWMULU, VWMULSU, VWMUL,
                                               VWMACCU, VWMACC, VWMACCUS, VWMACCSU};
        uop.vexec.vmulrethigh   = pkt.vopm inside {VMULHU, VMULHSU, VMULH};
        uop.vexec.vdivremainder = pkt.vopm inside {VREMU, VREM};
        // plain vwaddu/vwsubu leave this clear
        uop.vexec.vopunsigned = pkt.vopm inside {VREDMINU, VREDMAXU, VAADDU, VASUBU,
                                                 VDIVU, VREMU, VMULHU, VMULHSU,
                                                 VWADDU_W, VWSUBU_W, VWMULU, VWMULSU,
                                                 VWMACCU, VWMACCUS, VWMACCSU};

        // .w forms read a double-width vs2
        if (pkt.vopm inside {VWADDU_W, VWADD_W, VWSUBU_W, VWSUB_W}) begin
            uop.veew_src2 = vsew_t'(pkt.vsew + 3'd1);
        end

        uop.vs1     = pkt.vs1;
        uop.vs2     = pkt.vs2;
        uop.vd      = pkt.vd;
        uop.vm      = pkt.vm;
        uop.illegal = !pkt.opcode_ok || !known || !funct3_ok;
    end

endmodule

`default_nettype wire

// ==== logic/rv32v_vdecode_top.sv ====
// Top level of the OPM decode slice: bus front, field split, decode and two stage registers
`timescale 1ns/10ps
`default_nettype none

module rv32v_vdecode_top
    import rv32v_types_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n,
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  logic        wb_adr,
    input  logic [31:0] wb_dat_w,
    input  logic [3:0]  wb_sel,
    output logic        wb_ack,
    output logic [31:0] wb_dat_r,
    output logic        uop_valid,
    input  logic        uop_ready,
    output vexec_t      uop_vexec,
    output vsew_t       uop_veew_src2,
    output logic [4:0]  uop_vs1,
    output logic [4:0]  uop_vs2,
    output logic [4:0]  uop_vd,
    output logic        uop_vm,
    output logic        uop_illegal
);

    logic        slot_valid;
    logic        slot_ready;
    logic [31:0] slot_instr;
    vsew_t       slot_vsew;
    split_pkt_t  split_pkt;
    logic        sp_valid;
    logic        sp_ready;
    split_pkt_t  sp_pkt;
    uop_t        dec_uop;
    uop_t        out_uop;

    vdec_wb_front i_front (
        .clk       (clk),
        .arst_n    (arst_n),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_dat_w  (wb_dat_w),
        .wb_sel    (wb_sel),
        .wb_ack    (wb_ack),
        .wb_dat_r  (wb_dat_r),
        .out_valid (slot_valid),
        .out_ready (slot_ready),
        .out_instr (slot_instr),
        .out_vsew  (slot_vsew)
    );

    rv32v_field_split i_split (
        .instr (slot_instr),
        .vsew  (slot_vsew),
        .pkt   (split_pkt)
    );

    // slot valid/ready go straight to the first register
    vdec_pipe_reg #(.payload_t(split_pkt_t)) i_split_reg (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (slot_valid),
        .in_ready  (slot_ready),
        .in_data   (split_pkt),
        .out_valid (sp_valid),
        .out_ready (sp_ready),
        .out_data  (sp_pkt)
    );

    rv32v_opm_decode i_decode (
        .pkt (sp_pkt),
        .uop (dec_uop)
    );

    vdec_pipe_reg #(.payload_t(uop_t)) i_uop_reg (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (sp_valid),
        .in_ready  (sp_ready),
        .in_data   (dec_uop),
        .out_valid (uop_valid),
        .out_ready (uop_ready),
        .out_data  (out_uop)
    );

    assign uop_vexec     = out_uop.vexec;
    assign uop_veew_src2 = out_uop.veew_src2;
    assign uop_vs1       = out_uop.vs1;
    assign uop_vs2       = out_uop.vs2;
    assign uop_vd        = out_uop.vd;
    assign uop_vm        = out_uop.vm;
    assign uop_illegal   = out_uop.illegal;

endmodule

`default_nettype wire

// ==== tests/tb_vdecode_ref.svh ====
// Reference OPM decode model and expected-uop queue; included inside the decode testbench module

uop_t exp_q[$];   // expected uops in issue order

// expected uop for one instruction word at the given element width
function automatic uop_t ref_decode(input logic [31:0] instr, input logic [2:0] sew);
    uop_t       u;
    logic [5:0] f6;
    logic       known;
    f6          = instr[31:26];
    known       = 1'b1;
    u           = '0;
    u.veew_src2 = vsew_t'(sew);
    case (f6) inside
        [6'h00:6'h07]: begin   // reductions
            u.vexec.vfu = VFU_RED;
            case (f6[2:0])
                3'd1:       u.vexec.valuop = VALU_AND;
                3'd2:       u.vexec.valuop = VALU_OR;
                3'd3:       u.vexec.valuop = VALU_XOR;
                3'd4, 3'd5: u.vexec.valuop = VALU_MIN;
                3'd6, 3'd7: u.vexec.valuop = VALU_MAX;
                default:    u.vexec.valuop = VALU_ADD;
            endcase
            u.vexec.vopunsigned = (f6[2:0] == 3'd4) || (f6[2:0] == 3'd6);
        end
        [6'h08:6'h0b]: begin   // averaging add/sub
            u.vexec.valuop      = f6[1] ? VALU_SUB : VALU_ADD;
            u.vexec.vopunsigned = !f6[0];
        end
        6'h0e, 6'h0f, 6'h17: begin   // slide1 up/down, compress
            u.vexec.vfu = VFU_PRM;
            if (f6 == 6'h0e) u.vexec.vpermop = VPRM_S1U;
            if (f6 == 6'h0f) u.vexec.vpermop = VPRM_S1D;
        end
        [6'h18:6'h1f]: begin
            u.vexec.vfu = VFU_MSK;
            case (f6[2:0])
                3'd0:       u.vexec.vmaskop = VMSK_NDN;
                3'd2:       u.vexec.vmaskop = VMSK_OR;
                3'd3:       u.vexec.vmaskop = VMSK_XOR;
                3'd4, 3'd6: u.vexec.vmaskop = VMSK_NOR;   // vmorn encodes as nor
                3'd5:       u.vexec.vmaskop = VMSK_NND;
                3'd7:       u.vexec.vmaskop = VMSK_XNR;
                default:    u.vexec.vmaskop = VMSK_AND;
            endcase
        end
        [6'h20:6'h23]: begin   // divu, div, remu, rem
            u.vexec.vfu           = VFU_DIV;
            u.vexec.vdivremainder = f6[1];
            u.vexec.vopunsigned   = !f6[0];
        end
        [6'h24:6'h27]: begin   // mulhu, mul, mulhsu, mulh
            u.vexec.vfu         = VFU_MUL;
            u.vexec.vmulrethigh = (f6 != 6'h25);
            u.vexec.vopunsigned = !f6[0];
            if (f6 == 6'h24) u.vexec.vsigntype = UNSIGNED;
            if (f6 == 6'h26) u.vexec.vsigntype = SIGNED_UNSIGNED;
        end
        6'h29, 6'h2b, 6'h2d, 6'h2f: begin   // madd, nmsub, macc, nmsac
            u.vexec.vfu    = VFU_MUL;
            u.vexec.vmulop = vmulop_t'(f6[2:1] + 3'd1);
        end
        [6'h30:6'h37]: begin   // widening add/sub, .w forms from 34
            u.vexec.valuop      = f6[1] ? VALU_SUB : VALU_ADD;
            u.vexec.vopunsigned = f6[2] && !f6[0];
            if (f6[2]) u.veew_src2 = vsew_t'(sew + 3'd1);
        end
        6'h38, 6'h3a, 6'h3b: begin   // wmulu, wmulsu, wmul
            u.vexec.vfu         = VFU_MUL;
            u.vexec.vmulwiden   = 1'b1;
            u.vexec.vopunsigned = (f6 != 6'h3b);
            if (f6 == 6'h38) u.vexec.vsigntype = UNSIGNED;
            if (f6 == 6'h3a) u.vexec.vsigntype = SIGNED_UNSIGNED;
        end
        [6'h3c:6'h3f]: begin   // wmaccu, wmacc, wmaccus, wmaccsu
            u.vexec.vfu         = VFU_MUL;
            u.vexec.vmulwiden   = 1'b1;
            u.vexec.vmulop      = VMUL_MACC;
            u.vexec.vopunsigned = (f6[1:0] != 2'd1);
            case (f6[1:0])
                2'd0:    u.vexec.vsigntype = UNSIGNED;
                2'd2:    u.vexec.vsigntype = UNSIGNED_SIGNED;
                2'd3:    u.vexec.vsigntype = SIGNED_UNSIGNED;
                default: u.vexec.vsigntype = SIGNED;
            endcase
        end
        default: known = 1'b0;   // unary groups and unassigned codes
    endcase
    u.vs1     = instr[19:15];
    u.vs2     = instr[24:20];
    u.vd      = instr[11:7];
    u.vm      = instr[25];
    u.illegal = (instr[6:0] != 7'b1010111) || !(instr[14:12] inside {3'd2, 3'd6}) || !known;
    return u;
endfunction

task automatic expect_uop(input logic [31:0] word, input logic [2:0] sew);
    exp_q.push_back(ref_decode(word, sew));
endtask

// ==== tests/tb_vdecode.sv ====
// Testbench for the OPM decode slice: Wishbone stimulus, reference comparison and back-pressure
`timescale 1ns/10ps
`default_nettype none

module tb_vdecode import rv32v_types_pkg::*; ();

    localparam int reset_cycles = 10;
    localparam int n_random     = 300;
    localparam int n_stall      = 150;

    logic        clk;
    logic        arst_n;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic        wb_adr;
    logic [31:0] wb_dat_w;
    logic [3:0]  wb_sel;
    logic        wb_ack;
    logic [31:0] wb_dat_r;
    logic        uop_valid;
    logic        uop_ready = 1'b1;
    vexec_t      uop_vexec;
    vsew_t       uop_veew_src2;
    logic [4:0]  uop_vs1;
    logic [4:0]  uop_vs2;
    logic [4:0]  uop_vd;
    logic        uop_vm;
    logic        uop_illegal;
    logic [39:0] uop_bits;

    logic [2:0]  cur_sew;
    logic [31:0] stim_rng;
    logic [31:0] ready_rng = 32'h5b907351;
    logic        stall_mode = 1'b0;
    int          max_wait;
    int          bus_errors;
    int          stream_errors = 0;
    int          compared = 0;

    `include "tb_vdecode_ref.svh"

    rv32v_vdecode_top i_dut (.*);

    assign uop_bits = {uop_vexec, uop_veew_src2, uop_vs1, uop_vs2, uop_vd, uop_vm, uop_illegal};

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    function automatic logic [31:0] opm_word(input logic [5:0] f6, input logic [2:0] f3,
                                             input logic [6:0] opc, input logic [31:0] r);
        return {f6, r[25:15], f3, r[11:7], opc};   // register fields from r
    endfunction

    task automatic check_value(input string what, input logic [39:0] got,
                               input logic [39:0] exp, inout int errors);
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t ns: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
        end
    endtask

    // one classic cycle, starts and ends at a falling edge
    task automatic bus_cycle(input logic we, input logic adr, input logic [31:0] data,
                             output logic [31:0] rdata);
        int waits;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = data;
        wb_sel   = 4'hf;
        waits    = 0;
        @(negedge clk);
        while (!wb_ack) begin
            waits++;
            @(negedge clk);
        end
        rdata = wb_dat_r;   // transfer completes at the coming rising edge
        if (we && adr == wb_addr_instr) begin
            expect_uop(data, cur_sew);
            if (waits > max_wait) max_wait = waits;
        end
        if (we && adr == wb_addr_vsew) cur_sew = data[2:0];
        @(negedge clk);
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic compare_uop();
        uop_t e;
        if (exp_q.size() == 0) begin
            stream_errors++;
            $display("a uop came out at %0t ns with no instruction pending", $time);
            return;
        end
        e = exp_q.pop_front();
        compared++;
        check_value("illegal", 40'(uop_illegal), 40'(e.illegal), stream_errors);
        check_value("vs1", 40'(uop_vs1), 40'(e.vs1), stream_errors);
        check_value("vs2", 40'(uop_vs2), 40'(e.vs2), stream_errors);
        check_value("vd", 40'(uop_vd), 40'(e.vd), stream_errors);
        check_value("vm", 40'(uop_vm), 40'(e.vm), stream_errors);
        if (!e.illegal) begin   // controls of an illegal op are don't-care
            check_value("veew_src2", 40'(uop_veew_src2), 40'(e.veew_src2), stream_errors);
            check_value("vfu", 40'(uop_vexec.vfu), 40'(e.vexec.vfu), stream_errors);
            check_value("valuop", 40'(uop_vexec.valuop), 40'(e.vexec.valuop), stream_errors);
            check_value("vmulop", 40'(uop_vexec.vmulop), 40'(e.vexec.vmulop), stream_errors);
            check_value("vmulwiden", 40'(uop_vexec.vmulwiden), 40'(e.vexec.vmulwiden),
                        stream_errors);
            check_value("vmulrethigh", 40'(uop_vexec.vmulrethigh), 40'(e.vexec.vmulrethigh),
                        stream_errors);
            check_value("vdivremainder", 40'(uop_vexec.vdivremainder),
                        40'(e.vexec.vdivremainder), stream_errors);
            check_value("vmaskop", 40'(uop_vexec.vmaskop), 40'(e.vexec.vmaskop), stream_errors);
            check_value("vpermop", 40'(uop_vexec.vpermop), 40'(e.vexec.vpermop), stream_errors);
            check_value("vsigntype", 40'(uop_vexec.vsigntype), 40'(e.vexec.vsigntype),
                        stream_errors);
            check_value("vopunsigned", 40'(uop_vexec.vopunsigned), 40'(e.vexec.vopunsigned),
                        stream_errors);
        end
    endtask

    // output sink: picks uop_ready, compares taken uops, checks stalled ones hold
    always @(negedge clk) begin : sink
        logic        ready_now;
        logic        was_stalled;
        logic [39:0] held_bits;
        int          low_run;
        ready_rng = xorshift32(ready_rng);
        if (!stall_mode) begin
            ready_now = 1'b1;
        end else if (low_run > 0) begin
            ready_now = 1'b0;
            low_run--;
        end else if (ready_rng[7:4] == 4'd0) begin
            ready_now = 1'b0;   // start of a 20 cycle stall
            low_run   = 19;
        end else begin
            ready_now = ready_rng[0];
        end
        if (was_stalled) begin
            if (!uop_valid) begin
                stream_errors++;
                $display("uop_valid dropped at %0t ns while uop_ready was low", $time);
            end
            check_value("stalled uop payload", uop_bits, held_bits, stream_errors);
        end
        if (arst_n && uop_valid && ready_now) compare_uop();
        was_stalled = arst_n && uop_valid && !ready_now;
        held_bits   = uop_bits;
        uop_ready   = ready_now;
    end

    initial begin : stimulus
        logic [31:0] rd;
        logic [31:0] word;
        vopm_t       op;
        int          lat;
        wb_cyc     = 1'b0;
        wb_stb     = 1'b0;
        wb_we      = 1'b0;
        wb_adr     = 1'b0;
        wb_dat_w   = 32'd0;
        wb_sel     = 4'h0;
        arst_n     = 1'b0;
        cur_sew    = 3'd0;
        max_wait   = 0;
        bus_errors = 0;
        stim_rng   = 32'h5b907351;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);

        // vsew read-back, then one op through the empty pipeline
        bus_cycle(1'b1, wb_addr_vsew, 32'd2, rd);
        bus_cycle(1'b0, wb_addr_vsew, 32'd0, rd);
        check_value("vsew read-back", 40'(rd), 40'd2, bus_errors);
        bus_cycle(1'b0, wb_addr_instr, 32'd0, rd);
        check_value("instr address read", 40'(rd), 40'd0, bus_errors);
        bus_cycle(1'b1, wb_addr_instr, opm_word(VREDSUM, 3'd2, op_v_opcode, 32'h00a53c81), rd);
        lat = 0;
        while (!uop_valid) begin
            @(negedge clk);
            lat++;
        end
        if (lat < 1 || lat > 3) begin
            bus_errors++;
            $display("first uop took %0d cycles after the write ack, outside 1 to 3", lat);
        end

        // every named funct6 with funct3 2 at each width
        op = op.first();
        repeat (op.num()) begin
            for (int s = 0; s < 4; s++) begin
                stim_rng = xorshift32(stim_rng);
                bus_cycle(1'b1, wb_addr_vsew, 32'(s), rd);
                bus_cycle(1'b1, wb_addr_instr, opm_word(op, 3'd2, op_v_opcode, stim_rng), rd);
            end
            op = op.next();
        end

        // rejected funct3 values, and slot 2 reused for a wrong major opcode
        op = op.first();
        repeat (op.num()) begin
            for (int f = 0; f < 8; f++) begin
                stim_rng = xorshift32(stim_rng);
                if (f == 2) word = opm_word(op, 3'd2, 7'b0110011, stim_rng);
                else word = opm_word(op, 3'(f), op_v_opcode, stim_rng);
                if (f != 6) bus_cycle(1'b1, wb_addr_instr, word, rd);
            end
            op = op.next();
        end

        // random words back to back
        for (int n = 0; n < n_random; n++) begin
            stim_rng = xorshift32(stim_rng);
            if (n % 50 == 0) bus_cycle(1'b1, wb_addr_vsew, {30'd0, stim_rng[9:8]}, rd);
            word = stim_rng;
            if (word[7] || word[8]) word[6:0] = op_v_opcode;   // mostly OP-V
            bus_cycle(1'b1, wb_addr_instr, word, rd);
        end

        // random back-pressure with long stalls
        stall_mode = 1'b1;
        max_wait   = 0;
        for (int n = 0; n < n_stall; n++) begin
            stim_rng = xorshift32(stim_rng);
            word     = stim_rng;
            word[6:0]   = op_v_opcode;
            word[14:12] = stim_rng[0] ? 3'd6 : 3'd2;
            bus_cycle(1'b1, wb_addr_instr, word, rd);
        end
        stall_mode = 1'b0;
        if (max_wait < 5) begin
            bus_errors++;
            $display("instruction writes were never held off under back-pressure");
        end

        while (exp_q.size() != 0) @(negedge clk);
        repeat (20) @(negedge clk);   // room for any extra uop to show up
        $display("summary: %0d uops compared, %0d stream errors, %0d bus errors",
                 compared, stream_errors, bus_errors);
        if (stream_errors == 0 && bus_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    initial begin : watchdog
        vopm_t probe;
        int    limit;
        limit = reset_cycles + 200 * (2 + 11 * probe.num() + n_random + n_stall);
        repeat (limit) @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles", limit);
        $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+tests
logic/rv32v_types_pkg.sv
logic/vdec_wb_front.sv
logic/vdec_pipe_reg.sv
logic/rv32v_field_split.sv
logic/rv32v_opm_decode.sv
logic/rv32v_vdecode_top.sv
tests/tb_vdecode.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_vdecode
FILELIST  := files.f
OBJDIR    := obj_dir
SIM       := $(OBJDIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST)) tests/tb_vdecode_ref.svh

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -q '^\*\* PASS \*\*$$' $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
